// ==== hw/sort_cfg_pkg.sv ====
package sort_cfg_pkg;

    // Width of one unsigned word
    localparam int data_width = 16;

    // Largest block the buffers can hold
    localparam int max_length = 32;

    // Chunk handled by the serial transposition sorter
    localparam int chunk_size = 8;

    // Length count must hold max_length itself, hence the extra value
    localparam int length_width = $clog2(max_length + 1);

    // Word address inside one merge bank
    localparam int index_width = $clog2(max_length);

    // Position of a word inside a chunk
    localparam int chunk_index_width = $clog2(chunk_size);

    // Chunk counter covers four full chunks plus a partial one
    localparam int chunk_count_width = 3;

endpackage

// ==== hw/sort_ctrl_pkg.sv ====
package sort_ctrl_pkg;

    // Chunk sorter: take words in, run the network, hand the chunk on
    typedef enum logic [1:0] {
        chunk_collect,
        chunk_sort,
        chunk_emit
    } chunk_state_t;

    // Merging unit: store chunks, merge pass by pass, stream the block out
    typedef enum logic [1:0] {
        merge_fill,
        merge_merge,
        merge_drain
    } merge_state_t;

endpackage

// ==== hw/chunk_sorter.sv ====
`timescale 1ns/1ps

module chunk_sorter (
    input  logic                                     clock,
    input  logic                                     arst_n,
    input  logic [sort_cfg_pkg::chunk_index_width:0] chunk_len,
    input  logic [sort_cfg_pkg::data_width-1:0]      in_data,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    output logic [sort_cfg_pkg::data_width-1:0]      sorted_data,
    output logic                                     sorted_valid,
    input  logic                                     sorted_ready
);

    sort_ctrl_pkg::chunk_state_t state;

    logic [sort_cfg_pkg::data_width-1:0]        slots [sort_cfg_pkg::chunk_size];
    logic [sort_cfg_pkg::data_width-1:0]        swapped [sort_cfg_pkg::chunk_size];
    logic [sort_cfg_pkg::chunk_index_width-1:0] wr_idx;
    logic [sort_cfg_pkg::chunk_index_width-1:0] rd_idx;
    logic [sort_cfg_pkg::chunk_index_width-1:0] step;
    logic [sort_cfg_pkg::chunk_index_width:0]   held_len;
    logic                                       accept;
    logic                                       last_in;
    logic                                       emit_fire;
    logic                                       last_out;

    assign in_ready     = state == sort_ctrl_pkg::chunk_collect;
    assign accept       = in_valid && in_ready;
    assign last_in      = {1'b0, wr_idx} == chunk_len - 1'b1;
    assign sorted_valid = state == sort_ctrl_pkg::chunk_emit;
    assign sorted_data  = slots[rd_idx];
    assign emit_fire    = sorted_valid && sorted_ready;
    assign last_out     = {1'b0, rd_idx} == held_len - 1'b1;

    // Even steps compare pairs starting at slot 0, odd steps pairs starting at slot 1
    always_comb begin
        swapped = slots;
        for (int i = 0; i < sort_cfg_pkg::chunk_size - 1; i++) begin
            if (i[0] == step[0] && slots[i] > slots[i + 1]) begin
                swapped[i]     = slots[i + 1];
                swapped[i + 1] = slots[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            slots[wr_idx] <= in_data;
            // All-ones padding sinks to the top and is never emitted
            if (last_in) begin
                for (int i = 0; i < sort_cfg_pkg::chunk_size; i++) begin
                    if (i > wr_idx) begin
                        slots[i] <= '1;
                    end
                end
            end
        end else if (state == sort_ctrl_pkg::chunk_sort) begin
            slots <= swapped;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= sort_ctrl_pkg::chunk_collect;
            wr_idx   <= '0;
            rd_idx   <= '0;
            step     <= '0;
            held_len <= '0;
        end else begin
            case (state)
                sort_ctrl_pkg::chunk_collect: begin
                    if (accept) begin
                        if (last_in) begin
                            // The top moves on to the next chunk length right away
                            held_len <= chunk_len;
                            wr_idx   <= '0;
                            step     <= '0;
                            state    <= sort_ctrl_pkg::chunk_sort;
                        end else begin
                            wr_idx <= wr_idx + 1'b1;
                        end
                    end
                end
                sort_ctrl_pkg::chunk_sort: begin
                    step <= step + 1'b1;
                    if (step == '1) begin
                        rd_idx <= '0;
                        state  <= sort_ctrl_pkg::chunk_emit;
                    end
                end
                sort_ctrl_pkg::chunk_emit: begin
                    if (emit_fire) begin
                        rd_idx <= rd_idx + 1'b1;
                        if (last_out) begin
                            state <= sort_ctrl_pkg::chunk_collect;
                        end
                    end
                end
                default: state <= sort_ctrl_pkg::chunk_collect;
            endcase
        end
    end

    // Each word handed on is followed by one no smaller within the same chunk
    property chunk_ascending;
        @(posedge clock) disable iff (!arst_n)
            emit_fire && !last_out |=> sorted_data >= $past(sorted_data);
    endproperty
    assert property (chunk_ascending);

endmodule

// ==== hw/merging_unit.sv ====
`timescale 1ns/1ps

module merging_unit (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  block_start,
    input  logic [sort_cfg_pkg::length_width-1:0] block_len,
    input  logic [sort_cfg_pkg::data_width-1:0]   sorted_data,
    input  logic                                  sorted_valid,
    output logic                                  sorted_ready,
    output logic [sort_cfg_pkg::data_width-1:0]   out_data,
    output logic                                  out_valid,
    output logic                                  out_last,
    input  logic                                  out_ready,
    output logic                                  done
);

    sort_ctrl_pkg::merge_state_t state;

    logic [sort_cfg_pkg::data_width-1:0]   bank_a [sort_cfg_pkg::max_length];
    logic [sort_cfg_pkg::data_width-1:0]   bank_b [sort_cfg_pkg::max_length];
    logic [sort_cfg_pkg::length_width-1:0] len_q;
    logic [sort_cfg_pkg::length_width-1:0] width;
    logic [sort_cfg_pkg::length_width-1:0] base;
    logic [sort_cfg_pkg::length_width-1:0] lp;
    logic [sort_cfg_pkg::length_width-1:0] rp;
    logic [sort_cfg_pkg::length_width-1:0] addr;
    logic [sort_cfg_pkg::length_width-1:0] left_end;
    logic [sort_cfg_pkg::length_width-1:0] right_end;
    logic [sort_cfg_pkg::data_width-1:0]   left_word;
    logic [sort_cfg_pkg::data_width-1:0]   right_word;
    logic [sort_cfg_pkg::data_width-1:0]   merged_word;
    logic                                  src_sel;
    logic                                  pass_init;
    logic                                  left_ok;
    logic                                  right_ok;
    logic                                  take_left;
    logic                                  fill_fire;
    logic                                  drain_fire;
    logic                                  merge_step;

    // src_sel names the bank that holds the current runs, the other one is written
    assign sorted_ready = state == sort_ctrl_pkg::merge_fill;
    assign fill_fire    = sorted_valid && sorted_ready;
    assign merge_step   = state == sort_ctrl_pkg::merge_merge && !pass_init;
    assign out_valid    = state == sort_ctrl_pkg::merge_drain;
    assign out_data     = src_sel ? bank_b[addr[sort_cfg_pkg::index_width-1:0]]
                                  : bank_a[addr[sort_cfg_pkg::index_width-1:0]];
    assign out_last     = out_valid && addr == len_q - 1'b1;
    assign drain_fire   = out_valid && out_ready;

    // Runs are clipped at the block end, so a short tail run empties early
    assign left_end  = (base + width < len_q) ? base + width : len_q;
    assign right_end = (base + (width << 1) < len_q) ? base + (width << 1) : len_q;

    assign left_word  = src_sel ? bank_b[lp[sort_cfg_pkg::index_width-1:0]]
                                : bank_a[lp[sort_cfg_pkg::index_width-1:0]];
    assign right_word = src_sel ? bank_b[rp[sort_cfg_pkg::index_width-1:0]]
                                : bank_a[rp[sort_cfg_pkg::index_width-1:0]];
    assign left_ok    = lp < left_end;
    assign right_ok   = rp < right_end;
    // Ties go to the left run
    assign take_left   = left_ok && (!right_ok || left_word <= right_word);
    assign merged_word = take_left ? left_word : right_word;

    always_ff @(posedge clock) begin
        if (fill_fire) begin
            bank_a[addr[sort_cfg_pkg::index_width-1:0]] <= sorted_data;
        end else if (merge_step) begin
            if (src_sel) begin
                bank_a[addr[sort_cfg_pkg::index_width-1:0]] <= merged_word;
            end else begin
                bank_b[addr[sort_cfg_pkg::index_width-1:0]] <= merged_word;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= sort_ctrl_pkg::merge_fill;
            len_q     <= '0;
            width     <= '0;
            base      <= '0;
            lp        <= '0;
            rp        <= '0;
            addr      <= '0;
            src_sel   <= 1'b0;
            pass_init <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                sort_ctrl_pkg::merge_fill: begin
                    if (block_start) begin
                        len_q   <= block_len;
                        addr    <= '0;
                        src_sel <= 1'b0;
                        width   <= sort_cfg_pkg::length_width'(sort_cfg_pkg::chunk_size);
                    end else if (fill_fire) begin
                        addr <= addr + 1'b1;
                        if (addr == len_q - 1'b1) begin
                            addr      <= '0;
                            pass_init <= 1'b1;
                            // A block of one chunk is already sorted
                            state     <= (len_q > width) ? sort_ctrl_pkg::merge_merge
                                                         : sort_ctrl_pkg::merge_drain;
                        end
                    end
                end
                sort_ctrl_pkg::merge_merge: begin
                    if (pass_init) begin
                        pass_init <= 1'b0;
                        base      <= '0;
                        lp        <= '0;
                        rp        <= width;
                        addr      <= '0;
                    end else begin
                        addr <= addr + 1'b1;
                        if (take_left) begin
                            lp <= lp + 1'b1;
                        end else begin
                            rp <= rp + 1'b1;
                        end
                        // Pair finished, the next pair starts where this one ended
                        if (addr == right_end - 1'b1) begin
                            base <= right_end;
                            lp   <= right_end;
                            rp   <= right_end + width;
                        end
                        if (addr == len_q - 1'b1) begin
                            src_sel   <= !src_sel;
                            width     <= width << 1;
                            addr      <= '0;
                            pass_init <= 1'b1;
                            if ((width << 1) >= len_q) begin
                                state <= sort_ctrl_pkg::merge_drain;
                            end
                        end
                    end
                end
                sort_ctrl_pkg::merge_drain: begin
                    if (drain_fire) begin
                        addr <= addr + 1'b1;
                        if (out_last) begin
                            addr  <= '0;
                            done  <= 1'b1;
                            state <= sort_ctrl_pkg::merge_fill;
                        end
                    end
                end
                default: state <= sort_ctrl_pkg::merge_fill;
            endcase
        end
    end

    // A stalled word stays on the bus unchanged until it transfers
    property drain_held;
        @(posedge clock) disable iff (!arst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last);
    endproperty
    assert property (drain_held);

    // The merged block leaves in ascending order up to the word at the final index
    property drain_ascending;
        @(posedge clock) disable iff (!arst_n)
            drain_fire && !out_last |=> out_data >= $past(out_data);
    endproperty
    assert property (drain_ascending);

endmodule

// ==== hw/merge_sorter.sv ====
`timescale 1ns/1ps

module merge_sorter (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  start,
    input  logic [sort_cfg_pkg::length_width-1:0] length,
    input  logic [sort_cfg_pkg::data_width-1:0]   in_data,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    output logic [sort_cfg_pkg::data_width-1:0]   out_data,
    output logic                                  out_valid,
    output logic                                  out_last,
    input  logic                                  out_ready,
    output logic                                  done
);

    logic                                        busy;
    logic                                        block_start;
    logic [sort_cfg_pkg::length_width-1:0]       len_q;
    logic [sort_cfg_pkg::length_width-1:0]       in_count;
    logic [sort_cfg_pkg::chunk_count_width-1:0]  full_chunks;
    logic [sort_cfg_pkg::chunk_count_width-1:0]  chunk_cnt;
    logic [sort_cfg_pkg::chunk_index_width-1:0]  remainder;
    logic [sort_cfg_pkg::chunk_index_width:0]    chunk_len;
    logic                                        room;
    logic                                        accept;
    logic                                        sorter_in_valid;
    logic                                        sorter_in_ready;
    logic [sort_cfg_pkg::data_width-1:0]         sorted_data;
    logic                                        sorted_valid;
    logic                                        sorted_ready;

    // Length split into whole chunks and the size of a trailing partial chunk
    assign full_chunks = len_q[sort_cfg_pkg::length_width-1:sort_cfg_pkg::chunk_index_width];
    assign remainder   = len_q[sort_cfg_pkg::chunk_index_width-1:0];
    assign chunk_cnt   = in_count[sort_cfg_pkg::length_width-1:sort_cfg_pkg::chunk_index_width];

    // A full chunk length is the top bit alone, as the chunk size is a power of two
    assign chunk_len = (chunk_cnt == full_chunks && remainder != '0)
                       ? {1'b0, remainder}
                       : {1'b1, {sort_cfg_pkg::chunk_index_width{1'b0}}};

    // No word beyond the block length is let in
    assign room            = busy && in_count != len_q;
    assign in_ready        = room && sorter_in_ready;
    assign sorter_in_valid = in_valid && room;
    assign accept          = in_valid && in_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy        <= 1'b0;
            block_start <= 1'b0;
            len_q       <= '0;
            in_count    <= '0;
        end else begin
            block_start <= 1'b0;
            if (start && !busy) begin
                busy        <= 1'b1;
                block_start <= 1'b1;
                len_q       <= length;
                in_count    <= '0;
            end else begin
                if (accept) begin
                    in_count <= in_count + 1'b1;
                end
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    chunk_sorter chunk_sorter_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .chunk_len    (chunk_len),
        .in_data      (in_data),
        .in_valid     (sorter_in_valid),
        .in_ready     (sorter_in_ready),
        .sorted_data  (sorted_data),
        .sorted_valid (sorted_valid),
        .sorted_ready (sorted_ready)
    );

    merging_unit merging_unit_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .block_start  (block_start),
        .block_len    (len_q),
        .sorted_data  (sorted_data),
        .sorted_valid (sorted_valid),
        .sorted_ready (sorted_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_ready    (out_ready),
        .done         (done)
    );

    // Only one block may be in flight through the sorter and the merger
    property start_when_idle;
        @(posedge clock) disable iff (!arst_n)
            start |-> !busy;
    endproperty
    assert property (start_when_idle);

endmodule

// ==== test/merge_sorter_tb.sv ====
`timescale 1ns/1ps

module merge_sorter_tb;

    localparam int ready_timeout = 200;
    localparam int drain_timeout = 3000;

    logic                                  clock;
    logic                                  arst_n;
    logic                                  start;
    logic [sort_cfg_pkg::length_width-1:0] length;
    logic [sort_cfg_pkg::data_width-1:0]   in_data;
    logic                                  in_valid;
    logic                                  in_ready;
    logic [sort_cfg_pkg::data_width-1:0]   out_data;
    logic                                  out_valid;
    logic                                  out_last;
    logic                                  out_ready;
    logic                                  done;

    logic [31:0]                           rng_state;
    logic [sort_cfg_pkg::data_width-1:0]   model [$];
    string                                 test_name;
    int                                    errors;
    int                                    words_checked;
    int                                    blocks_run;

    merge_sorter merge_sorter_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .length    (length),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .done      (done)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Some all-ones words land next to the padding, and a narrow value range forces duplicates
    function automatic logic [sort_cfg_pkg::data_width-1:0] make_word(input logic [31:0] r,
                                                                      input bit few_values);
        if (r[7:4] == 4'h0) begin
            return '1;
        end
        if (few_values) begin
            return sort_cfg_pkg::data_width'(r[19:16]);
        end
        return r[31:32-sort_cfg_pkg::data_width];
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("MISMATCH %s: expected %0h, actual %0h at %0t", what, expected, actual, $time);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    // Plain insertion sort of the recorded input words
    task automatic sort_model();
        logic [sort_cfg_pkg::data_width-1:0] key;
        int                                  j;
        for (int i = 1; i < model.size(); i++) begin
            key = model[i];
            j   = i - 1;
            while (j >= 0 && model[j] > key) begin
                model[j + 1] = model[j];
                j--;
            end
            model[j + 1] = key;
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the last transfer
    task automatic feed_words(input int len, input bit few_values);
        logic [31:0] r;
        int          waits;
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            if (r[15:13] == 3'd0) begin
                in_valid = 1'b0;
                @(negedge clock);
            end
            in_valid = 1'b1;
            in_data  = make_word(r, few_values);
            waits    = 0;
            while (!in_ready && waits < ready_timeout) begin
                assert (!out_valid)
                    else report_failure($sformatf("%s: output valid during input", test_name));
                @(negedge clock);
                waits++;
            end
            assert (in_ready)
                else report_failure($sformatf("%s: input word %0d never accepted", test_name, i));
            model.push_back(in_data);
            @(negedge clock);
        end
        in_valid = 1'b0;
        assert (!in_ready)
            else report_failure($sformatf("%s: input ready after the last word", test_name));
    endtask

    task automatic drain_words(input int len);
        logic [31:0]                         r;
        logic [sort_cfg_pkg::data_width-1:0] expected;
        bit                                  expected_last;
        int                                  count;
        int                                  waits;
        count = 0;
        waits = 0;
        while (count < len && waits < drain_timeout) begin
            r = next_rand();
            // Ready is low about a quarter of the time
            out_ready = r[31:30] != 2'b00;
            assert (!in_ready)
                else report_failure($sformatf("%s: input ready while sorting", test_name));
            if (out_valid && out_ready) begin
                expected      = model[count];
                expected_last = count == len - 1;
                assert (out_data == expected)
                    else report_mismatch($sformatf("%s word %0d", test_name, count),
                                         expected, out_data);
                assert (out_last == expected_last)
                    else report_mismatch($sformatf("%s last flag %0d", test_name, count),
                                         expected_last, out_last);
                count++;
                words_checked++;
            end
            @(negedge clock);
            waits++;
        end
        assert (count == len)
            else report_failure($sformatf("%s: timed out after %0d of %0d output words",
                                          test_name, count, len));
        out_ready = 1'b0;
        assert (done)
            else report_failure($sformatf("%s: done missing after the last word", test_name));
        assert (!out_valid)
            else report_failure($sformatf("%s: extra output word after the last", test_name));
        @(negedge clock);
        assert (!done)
            else report_failure($sformatf("%s: done longer than one cycle", test_name));
    endtask

    task automatic run_block(input string name, input int len, input bit few_values);
        test_name = name;
        model.delete();
        @(negedge clock);
        assert (!in_ready && !out_valid && !done)
            else report_failure($sformatf("%s: sorter not idle before start", name));
        start  = 1'b1;
        length = sort_cfg_pkg::length_width'(len);
        @(negedge clock);
        start = 1'b0;
        feed_words(len, few_values);
        sort_model();
        drain_words(len);
        blocks_run++;
        repeat (2) begin
            @(negedge clock);
            assert (!out_valid && !done)
                else report_failure($sformatf("%s: output active between blocks", name));
        end
    endtask

    property stall_holds_word;
        @(posedge clock) disable iff (!arst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last);
    endproperty
    assert property (stall_holds_word)
        else report_failure("output word changed while stalled");

    property done_after_last;
        @(posedge clock) disable iff (!arst_n)
            out_valid && out_ready && out_last |=> done;
    endproperty
    assert property (done_after_last)
        else report_failure("done did not follow the last transfer");

    property done_only_after_last;
        @(posedge clock) disable iff (!arst_n)
            done |-> $past(out_valid && out_ready && out_last);
    endproperty
    assert property (done_only_after_last)
        else report_failure("done pulsed without a last transfer before it");

    property last_needs_valid;
        @(posedge clock) disable iff (!arst_n)
            out_last |-> out_valid;
    endproperty
    assert property (last_needs_valid)
        else report_failure("last flag high without a valid word");

    initial begin
        logic [31:0] r;
        int          rand_len;
        errors        = 0;
        words_checked = 0;
        blocks_run    = 0;
        rng_state     = 32'd11;
        arst_n        = 1'b0;
        start         = 1'b0;
        length        = '0;
        in_data       = '0;
        in_valid      = 1'b0;
        out_ready     = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        repeat (3) begin
            @(negedge clock);
            assert (!in_ready && !out_valid && !out_last && !done)
                else report_failure("outputs not low after reset");
        end

        run_block("len_1", 1, 1'b0);
        run_block("len_5", 5, 1'b1);
        run_block("len_8", 8, 1'b0);
        run_block("len_19", 19, 1'b1);
        run_block("len_32", 32, 1'b0);
        repeat (2) begin
            r        = next_rand();
            rand_len = int'(r[28:24]) + 1;
            run_block($sformatf("rand_len_%0d", rand_len), rand_len, r[20]);
        end

        $display("Sorted %0d blocks, checked %0d words, %0d errors",
                 blocks_run, words_checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/sort_cfg_pkg.sv
hw/sort_ctrl_pkg.sv
hw/chunk_sorter.sv
hw/merging_unit.sv
hw/merge_sorter.sv
test/merge_sorter_tb.sv

// ==== Bender.yml ====
package:
  name: merge_sorter

dependencies: {}

sources:
  # Packages first, then the datapath, then the top level
  - files:
      - hw/sort_cfg_pkg.sv
      - hw/sort_ctrl_pkg.sv
      - hw/chunk_sorter.sv
      - hw/merging_unit.sv
      - hw/merge_sorter.sv

  - target: test
    files:
      - test/merge_sorter_tb.sv
